// ==== src/ntt_params.svh ====
// Sizes fixed for a 128-point transform over q = 12289; other values are not supported
`ifndef NTT_PARAMS_SVH
`define NTT_PARAMS_SVH

// ----------------------------------------------------------------------
// Transform
// ----------------------------------------------------------------------
`define NTT_N           128
`define NTT_LOG_N       7
`define NTT_Q           12289

// -q^-1 mod 2^16, Montgomery radix 2^16
`define NTT_QINV_NEG    12287
`define NTT_MONT_SHIFT  16

// ----------------------------------------------------------------------
// Data widths and buffering
// ----------------------------------------------------------------------
`define IN_WORD_W       32
`define NIBBLE_W        4
`define COEFFS_PER_WORD 8
`define LOAD_BEATS      16
`define COEFF_W         16

// Result FIFO entries, power of two
`define FIFO_DEPTH      16

`endif

// ==== src/ntt_pkg.sv ====
// Twiddles are Montgomery-form constants for q = 12289 and only fit the 128-point order
`default_nettype none

`include "ntt_params.svh"

package ntt_pkg;

    typedef logic [`IN_WORD_W-1:0]           word_t;
    typedef logic [`COEFF_W-1:0]             coeff_t;
    typedef logic [$clog2(`NTT_N)-1:0]       addr_t;
    typedef logic [$clog2(`NTT_Q)-1:0]       twiddle_t;
    typedef logic [$clog2(`LOAD_BEATS)-1:0]  beat_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_LOAD    = 2'd1,
        ST_COMPUTE = 2'd2,
        ST_WRITE   = 2'd3
    } engine_state_e;

    // ------------------------------------------------------------------
    // Twiddle table, indexed by (1 << stage) + group
    // ------------------------------------------------------------------
    localparam twiddle_t TWIDDLE_ROM [`NTT_N] = '{
        14'd4091,  14'd7888,  14'd11060, 14'd11208, 14'd6960,  14'd4342,  14'd6275,  14'd9759,
        14'd1591,  14'd6399,  14'd9477,  14'd5266,  14'd586,   14'd5825,  14'd7538,  14'd9710,
        14'd1134,  14'd6407,  14'd1711,  14'd965,   14'd7099,  14'd7674,  14'd3743,  14'd6442,
        14'd10414, 14'd8100,  14'd1885,  14'd1688,  14'd1364,  14'd10329, 14'd10164, 14'd9180,
        14'd12210, 14'd6240,  14'd997,   14'd117,   14'd4783,  14'd4407,  14'd1549,  14'd7072,
        14'd2829,  14'd6458,  14'd4431,  14'd8877,  14'd7144,  14'd2564,  14'd5664,  14'd4042,
        14'd12189, 14'd432,   14'd10751, 14'd1237,  14'd7610,  14'd1534,  14'd3983,  14'd7863,
        14'd2181,  14'd6308,  14'd8720,  14'd6570,  14'd4843,  14'd1690,  14'd14,    14'd3872,
        14'd5569,  14'd9368,  14'd12163, 14'd2019,  14'd7543,  14'd2315,  14'd4673,  14'd7340,
        14'd1553,  14'd1156,  14'd8401,  14'd11389, 14'd1020,  14'd2967,  14'd10772, 14'd7045,
        14'd3316,  14'd11236, 14'd5285,  14'd11578, 14'd10637, 14'd10086, 14'd9493,  14'd6180,
        14'd9277,  14'd6130,  14'd3323,  14'd883,   14'd10469, 14'd489,   14'd1502,  14'd2851,
        14'd11061, 14'd9729,  14'd2742,  14'd12241, 14'd4970,  14'd10481, 14'd10078, 14'd1195,
        14'd730,   14'd1762,  14'd3854,  14'd2030,  14'd5892,  14'd10922, 14'd9020,  14'd5274,
        14'd9179,  14'd3604,  14'd3782,  14'd10206, 14'd3180,  14'd3467,  14'd4668,  14'd2446,
        14'd7613,  14'd9386,  14'd834,   14'd7703,  14'd6836,  14'd3403,  14'd5351,  14'd12276
    };

endpackage

`default_nettype wire

// ==== src/butterfly_if.sv ====
// Results for an issue are valid exactly one cycle after it; no handshake back to the engine
`timescale 1ns/1ps
`default_nettype none

interface butterfly_if;
    import ntt_pkg::*;

    // Operands, driven in the issue cycle
    logic     issue;
    coeff_t   a;
    coeff_t   b;
    twiddle_t w;

    // Results, one cycle later
    coeff_t   sum;
    coeff_t   diff;

    modport engine (output issue, a, b, w, input sum, diff);
    modport butterfly (input issue, a, b, w, output sum, diff);

endinterface

`default_nettype wire

// ==== src/mont_butterfly.sv ====
// Operands a, b and w must already lie in [0, q); outputs hold until the next issue
`timescale 1ns/1ps
`default_nettype none

`include "ntt_params.svh"

module mont_butterfly (
    input  logic           clk,
    input  logic           rst_n,
    butterfly_if.butterfly bf
);
    import ntt_pkg::*;

    localparam int     PROD_W = $bits(coeff_t) + $bits(twiddle_t);
    localparam int     ACC_W  = 2 * `NTT_MONT_SHIFT;
    localparam coeff_t Q      = coeff_t'(`NTT_Q);

    coeff_t                     a_q;
    logic [PROD_W-1:0]          prod_q;
    logic [ACC_W-1:0]           m_full;
    logic [`NTT_MONT_SHIFT-1:0] m;
    logic [ACC_W-1:0]           acc;
    coeff_t                     z;
    coeff_t                     t;
    coeff_t                     sum_raw;

    // Issue stage, product b*w kept whole
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q    <= '0;
            prod_q <= '0;
        end else if (bf.issue) begin
            a_q    <= bf.a;
            prod_q <= PROD_W'(bf.b) * PROD_W'(bf.w);
        end
    end

    // Montgomery reduction: z = (p + m*q) / 2^16, below 2q
    always_comb begin
        m_full  = ACC_W'(prod_q[`NTT_MONT_SHIFT-1:0]) * ACC_W'(`NTT_QINV_NEG);
        m       = m_full[`NTT_MONT_SHIFT-1:0];
        acc     = ACC_W'(prod_q) + ACC_W'(m) * ACC_W'(`NTT_Q);
        z       = coeff_t'(acc >> `NTT_MONT_SHIFT);
        t       = (z >= Q) ? z - Q : z;
        sum_raw = a_q + t;
        bf.sum  = (sum_raw >= Q) ? sum_raw - Q : sum_raw;
        bf.diff = (a_q >= t) ? a_q - t : a_q + Q - t;
    end

endmodule

`default_nettype wire

// ==== src/ntt_engine.sv ====
// One transform at a time; input beats are dropped while busy, FIFO writes wait on full
`timescale 1ns/1ps
`default_nettype none

`include "ntt_params.svh"

module ntt_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  ntt_pkg::word_t  in_data,
    output logic            busy,
    butterfly_if.engine     bf,
    output logic            wr_en,
    output ntt_pkg::coeff_t wr_data,
    input  logic            full
);
    import ntt_pkg::*;

    localparam int BFLY_W  = $clog2(`NTT_N / 2);
    localparam int STAGE_W = $clog2(`NTT_LOG_N + 1);

    engine_state_e      state;
    engine_state_e      state_nxt;
    beat_t              beat_cnt;
    logic [STAGE_W-1:0] stage;
    logic [BFLY_W-1:0]  bfly;
    addr_t              wr_idx;
    coeff_t             x [`NTT_N];

    logic               load_acc;
    logic               issue;
    addr_t              bfly_ext;
    addr_t              ht;
    addr_t              ht_mask;
    logic [STAGE_W-1:0] log_ht;
    addr_t              grp;
    addr_t              j_addr;
    addr_t              jht_addr;
    addr_t              tw_idx;

    logic               wb_en;
    addr_t              j_q;
    addr_t              jht_q;

    assign load_acc = in_valid && (state == ST_IDLE || state == ST_LOAD);
    assign issue    = (state == ST_COMPUTE) && (stage != STAGE_W'(`NTT_LOG_N));
    assign busy     = (state == ST_COMPUTE) || (state == ST_WRITE);
    assign wr_en    = (state == ST_WRITE) && !full;
    assign wr_data  = x[wr_idx];

    // ------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_LOAD: begin
                if (load_acc)
                    state_nxt = (beat_cnt == beat_t'(`LOAD_BEATS - 1)) ? ST_COMPUTE : ST_LOAD;
            end
            ST_COMPUTE: begin
                // Stage LOG_N is the write-back only cycle
                if (stage == STAGE_W'(`NTT_LOG_N))
                    state_nxt = ST_WRITE;
            end
            ST_WRITE: begin
                if (wr_en && wr_idx == addr_t'(`NTT_N - 1))
                    state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            stage    <= '0;
            bfly     <= '0;
            wr_idx   <= '0;
            wb_en    <= 1'b0;
        end else begin
            wb_en <= issue;
            if (load_acc)
                beat_cnt <= beat_cnt + 1'b1;
            if (issue) begin
                bfly <= bfly + 1'b1;
                if (&bfly)
                    stage <= stage + 1'b1;
            end else if (state == ST_COMPUTE) begin
                stage <= '0;
            end
            if (wr_en)
                wr_idx <= wr_idx + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Butterfly addressing
    // ------------------------------------------------------------------
    // j is the butterfly count with a zero slipped in at bit log2(ht)
    always_comb begin
        bfly_ext = addr_t'(bfly);
        ht       = addr_t'(`NTT_N / 2) >> stage;
        ht_mask  = ht - addr_t'(1);
        log_ht   = STAGE_W'(`NTT_LOG_N - 1) - stage;
        grp      = bfly_ext >> log_ht;
        j_addr   = ((bfly_ext & ~ht_mask) << 1) | (bfly_ext & ht_mask);
        jht_addr = j_addr + ht;
        tw_idx   = (addr_t'(1) << stage) + grp;
    end

    assign bf.issue = issue;
    assign bf.a     = x[j_addr];
    assign bf.b     = x[jht_addr];
    assign bf.w     = TWIDDLE_ROM[tw_idx];

    // Addresses follow the results by one cycle
    always_ff @(posedge clk) begin
        if (issue) begin
            j_q   <= j_addr;
            jht_q <= jht_addr;
        end
    end

    // ------------------------------------------------------------------
    // Sample memory
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_acc) begin
            for (int k = 0; k < `COEFFS_PER_WORD; k++) begin
                x[addr_t'(int'(beat_cnt) * `COEFFS_PER_WORD + k)] <=
                    coeff_t'(in_data[k * `NIBBLE_W +: `NIBBLE_W]);
            end
        end
        if (wb_en) begin
            x[j_q]   <= bf.sum;
            x[jht_q] <= bf.diff;
        end
    end

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
// DEPTH must be a power of two, at least 2; writes when full and reads when empty are dropped
`timescale 1ns/1ps
`default_nettype none

`include "ntt_params.svh"

module sample_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  ntt_pkg::coeff_t wr_data,
    output logic            full,
    input  logic            rd_en,
    output ntt_pkg::coeff_t rd_data,
    output logic            empty
);
    import ntt_pkg::*;

    localparam int AW = $clog2(DEPTH);

    coeff_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;
    assign full    = (count == (AW + 1)'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];

    // Pointers wrap by themselves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

// ==== src/sample_drain.sv ====
// Samples leave one cycle after they are read; out_ready has no skid, so it gates reads directly
`timescale 1ns/1ps
`default_nettype none

module sample_drain (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            out_ready,
    input  logic            empty,
    input  ntt_pkg::coeff_t rd_data,
    output logic            rd_en,
    output logic            out_valid,
    output ntt_pkg::coeff_t out_data
);

    assign rd_en = out_ready && !empty;

    // Valid follows the read event
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= rd_en;
    end

    // Head entry captured on read
    always_ff @(posedge clk) begin
        if (rd_en)
            out_data <= rd_data;
    end

endmodule

`default_nettype wire

// ==== src/ntt_top.sv ====
// Single clock; output starts only after compute ends, so back-pressure holds busy high
`timescale 1ns/1ps
`default_nettype none

`include "ntt_params.svh"

module ntt_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  ntt_pkg::word_t  in_data,
    output logic            busy,
    input  logic            out_ready,
    output logic            out_valid,
    output ntt_pkg::coeff_t out_data
);
    import ntt_pkg::*;

    logic   fifo_wr_en;
    coeff_t fifo_wr_data;
    logic   fifo_full;
    logic   fifo_rd_en;
    coeff_t fifo_rd_data;
    logic   fifo_empty;

    butterfly_if bf_if ();

    // ------------------------------------------------------------------
    // Transform core
    // ------------------------------------------------------------------
    ntt_engine u_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .busy     (busy),
        .bf       (bf_if.engine),
        .wr_en    (fifo_wr_en),
        .wr_data  (fifo_wr_data),
        .full     (fifo_full)
    );

    mont_butterfly u_butterfly (
        .clk   (clk),
        .rst_n (rst_n),
        .bf    (bf_if.butterfly)
    );

    // ------------------------------------------------------------------
    // Output path
    // ------------------------------------------------------------------
    sample_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .full    (fifo_full),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    sample_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_ready (out_ready),
        .empty     (fifo_empty),
        .rd_data   (fifo_rd_data),
        .rd_en     (fifo_rd_en),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== dv/ntt_ref.svh ====
// Behavioral model for the testbench only; coefficients must already lie below q
`ifndef NTT_REF_SVH
`define NTT_REF_SVH

// Square and multiply, operands below 2^31
function automatic longint pow_mod(input longint base, input longint exp_v, input longint m);
    longint result;
    longint b;
    longint e;
    result = 1;
    b      = base % m;
    e      = exp_v;
    while (e > 0) begin
        if (e % 2 == 1)
            result = (result * b) % m;
        b = (b * b) % m;
        e = e / 2;
    end
    return result;
endfunction

// b * w * 2^-16 mod q, through the inverse of the radix (Fermat)
function automatic int mont_mul_ref(input int b, input int w);
    longint r_mod;
    longint r_inv;
    r_mod = (longint'(1) << `NTT_MONT_SHIFT) % `NTT_Q;
    r_inv = pow_mod(r_mod, `NTT_Q - 2, `NTT_Q);
    return int'(((longint'(b) * longint'(w)) % `NTT_Q) * r_inv % `NTT_Q);
endfunction

// In-place Cooley-Tukey, one twiddle per group
function automatic void ntt_forward(inout int x [`NTT_N]);
    int ht;
    int w;
    int t;
    int a;
    int j0;
    for (int s = 0; s < `NTT_LOG_N; s++) begin
        ht = (`NTT_N / 2) >> s;
        for (int g = 0; g < (1 << s); g++) begin
            w  = int'(TWIDDLE_ROM[(1 << s) + g]);
            j0 = g * 2 * ht;
            for (int j = j0; j < j0 + ht; j++) begin
                t         = mont_mul_ref(x[j + ht], w);
                a         = x[j];
                x[j]      = (a + t) % `NTT_Q;
                x[j + ht] = (a - t + `NTT_Q) % `NTT_Q;
            end
        end
    end
endfunction

`endif

// ==== dv/ntt_tb.sv ====
// Runs whole transforms through the top level; one transform in flight, outputs sampled at negedge
`timescale 1ns/1ps
`default_nettype none

`include "ntt_params.svh"

module ntt_tb;
    import ntt_pkg::*;

    `include "ntt_ref.svh"

    typedef enum int {PAT_ZERO, PAT_IMPULSE, PAT_FIFTEEN, PAT_RANDOM} pattern_e;
    typedef enum int {RDY_ALWAYS, RDY_RANDOM} ready_e;

    typedef struct {
        string    name;
        pattern_e pattern;
        int       impulse_idx;
        ready_e   ready_mode;
        bit       inject;
    } row_t;

    localparam int NUM_ROWS    = 9;
    localparam int CYCLE_LIMIT = NUM_ROWS * (`LOAD_BEATS + 449 + 4 * `NTT_N + 100);

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    word_t  in_data;
    logic   busy;
    logic   out_ready;
    logic   out_valid;
    coeff_t out_data;

    row_t   rows [NUM_ROWS];
    int     coeffs [`NTT_N];
    int     expected [`NTT_N];
    word_t  words [`LOAD_BEATS];
    int     got;
    int     cycles = 0;
    int     seed_rng;

    ntt_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Failure reporting and compares
    // ------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sample(input string name, input coeff_t exp_v, input coeff_t act);
        if (act !== exp_v)
            abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp_v, act));
    endtask

    task automatic check_count(input string name, input int exp_v, input int act);
        if (act != exp_v)
            abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp_v, act));
    endtask

    task automatic check_level(input string name, input logic exp_v, input logic act);
        if (act !== exp_v)
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp_v, act));
    endtask

    // Hang guard over the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run("The run hung: the DUT produced no complete result within the cycle limit");
    end

    // ------------------------------------------------------------------
    // Stimulus table and helpers
    // ------------------------------------------------------------------
    task automatic fill_table();
        rows[0] = '{"zero",          PAT_ZERO,    0,  RDY_ALWAYS, 1'b0};
        rows[1] = '{"impulse_0",     PAT_IMPULSE, 0,  RDY_ALWAYS, 1'b0};
        rows[2] = '{"impulse_77",    PAT_IMPULSE, 77, RDY_ALWAYS, 1'b0};
        rows[3] = '{"all_fifteen",   PAT_FIFTEEN, 0,  RDY_ALWAYS, 1'b0};
        rows[4] = '{"random_a",      PAT_RANDOM,  0,  RDY_ALWAYS, 1'b0};
        rows[5] = '{"random_bp",     PAT_RANDOM,  0,  RDY_RANDOM, 1'b0};
        rows[6] = '{"fifteen_bp",    PAT_FIFTEEN, 0,  RDY_RANDOM, 1'b0};
        rows[7] = '{"random_inject", PAT_RANDOM,  0,  RDY_RANDOM, 1'b1};
        rows[8] = '{"random_after",  PAT_RANDOM,  0,  RDY_ALWAYS, 1'b0};
    endtask

    // Coefficients, packed words and expected samples for one row
    task automatic prepare_row(input int r);
        for (int i = 0; i < `NTT_N; i++) begin
            case (rows[r].pattern)
                PAT_ZERO:    coeffs[i] = 0;
                PAT_IMPULSE: coeffs[i] = (i == rows[r].impulse_idx) ? 1 : 0;
                PAT_FIFTEEN: coeffs[i] = 15;
                default:     coeffs[i] = int'($urandom_range(0, 15));
            endcase
        end
        for (int b = 0; b < `LOAD_BEATS; b++) begin
            words[b] = '0;
            for (int n = 0; n < `COEFFS_PER_WORD; n++)
                words[b][n * `NIBBLE_W +: `NIBBLE_W] = 4'(coeffs[b * `COEFFS_PER_WORD + n]);
        end
        expected = coeffs;
        ntt_forward(expected);
    endtask

    task automatic drive(input logic valid, input word_t data, input ready_e mode);
        in_valid = valid;
        in_data  = data;
        if (mode == RDY_ALWAYS)
            out_ready = 1'b1;
        else
            out_ready = 1'($urandom_range(0, 1));
    endtask

    // Called right after a falling edge, before new inputs go out
    task automatic observe(input int r);
        if (out_valid === 1'b1) begin
            check_level($sformatf("%s ready_before_valid", rows[r].name), 1'b1, out_ready);
            if (got >= `NTT_N)
                check_count($sformatf("%s sample_count", rows[r].name), `NTT_N, got + 1);
            check_sample($sformatf("%s sample[%0d]", rows[r].name, got),
                         coeff_t'(expected[got]), out_data);
            got++;
        end
    endtask

    task automatic run_row(input int r);
        got = 0;
        prepare_row(r);
        // Load, with random gaps between beats
        for (int beat = 0; beat < `LOAD_BEATS; beat++) begin
            while ($urandom_range(0, 3) == 0) begin
                drive(1'b0, '0, rows[r].ready_mode);
                @(negedge clk);
                observe(r);
            end
            check_level($sformatf("%s busy_during_load", rows[r].name), 1'b0, busy);
            drive(1'b1, words[beat], rows[r].ready_mode);
            @(negedge clk);
            observe(r);
        end
        check_level($sformatf("%s busy_rise", rows[r].name), 1'b1, busy);
        // Compute, write and drain; junk beats only while busy
        while (got < `NTT_N || busy === 1'b1) begin
            if (rows[r].inject && busy === 1'b1)
                drive(1'b1, word_t'($urandom), rows[r].ready_mode);
            else
                drive(1'b0, '0, rows[r].ready_mode);
            @(negedge clk);
            observe(r);
            if (got == `NTT_N)
                check_level($sformatf("%s busy_fall", rows[r].name), 1'b0, busy);
        end
        // A few quiet cycles catch repeated samples
        repeat (4) begin
            drive(1'b0, '0, RDY_ALWAYS);
            @(negedge clk);
            observe(r);
        end
        check_count($sformatf("%s sample_count", rows[r].name), `NTT_N, got);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        seed_rng  = $urandom(88981);
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        fill_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // Idle after reset
        for (int i = 0; i < 20; i++) begin
            drive(1'b0, '0, RDY_ALWAYS);
            @(negedge clk);
            check_level("reset_busy", 1'b0, busy);
            check_level("reset_out_valid", 1'b0, out_valid);
        end
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
+incdir+dv
src/ntt_pkg.sv
src/butterfly_if.sv
src/mont_butterfly.sv
src/ntt_engine.sv
src/sample_fifo.sv
src/sample_drain.sv
src/ntt_top.sv
dv/ntt_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the NTT testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module ntt_tb -o ntt_sim

# The simulator exits non-zero on a failed check, the log search below reports it
./obj_dir/ntt_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
